// ==== project.f ====
+incdir+.
systolic_pkg.sv
mac_unit.sv
processing_element.sv
systolic_array.sv
skew_feeder.sv
wb_systolic_ctrl.sv
systolic_top.sv
tb_systolic_top.sv

// ==== Makefile ====
# Verilator flow for the systolic multiplier
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       ?= tb_systolic_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# The run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_systolic_top.sv ====
// ====================
// Testbench for the Wishbone systolic multiplier
// Expected C is recomputed as integer sums of sign-extended products
// Stops at the first mismatch
// ====================
`timescale 1ns/10ps
`include "systolic_macros.svh"

module tb_systolic_top import systolic_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int NN           = `SA_N * `SA_N;
    localparam int N_TAB        = 5;
    localparam int N_RAND       = 20;
    // Table runs plus one rerun, one busy-write run and the random runs
    localparam int N_RUNS       = N_TAB + 2 + N_RAND;
    localparam int WATCHDOG_CYC = N_RUNS * 200 + 500;
    localparam int ACK_LIMIT    = 4;
    localparam int POLL_LIMIT   = 50;

    // ====================
    // Stimulus table
    // ====================
    // Raw S5.10 codes for A in row major order
    localparam int TAB_A [N_TAB][NN] = '{
        '{1, 0, 0, 1},
        '{1024, -2048, 512, 3},
        '{-32768, -32768, -32768, -32768},
        '{32767, -32768, 32767, 32767},
        '{-1, -1, -1, -1}
    };
    // Raw S1.6 codes for B in row major order
    localparam int TAB_B [N_TAB][NN] = '{
        '{5, -3, 7, 2},
        '{64, -64, 10, -1},
        '{-128, -128, -128, -128},
        '{127, -128, -128, 127},
        '{-1, 1, -1, 1}
    };

    // Readback patterns with upper bits that the slave drops
    localparam wb_data_t RB_A [NN] = '{
        32'hFFFF_8001, 32'h0001_7FFF, 32'h0000_0400, 32'hABCD_FC00
    };
    localparam wb_data_t RB_B [NN] = '{
        32'h1234_5680, 32'h0000_007F, 32'hFFFF_FF40, 32'h0000_0101
    };

    logic     clk;
    logic     rst_n;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;

    systolic_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // Reference model
    // ====================
    // Low 16 bits sign-extended to the bus width
    function automatic wb_data_t sext_data(input wb_data_t v);
        return wb_data_t'(int'(data_t'(v)));
    endfunction

    // Low 8 bits sign-extended to the bus width
    function automatic wb_data_t sext_weight(input wb_data_t v);
        return wb_data_t'(int'(weight_t'(v)));
    endfunction

    // C[i][j] as a plain integer dot product
    function automatic int expect_c(input int a_m [NN], input int b_m [NN],
                                    input int i, input int j);
        int sum;
        sum = 0;
        for (int k = 0; k < `SA_N; k++) begin
            sum += int'(data_t'(a_m[i*`SA_N+k])) * int'(weight_t'(b_m[k*`SA_N+j]));
        end
        return sum;
    endfunction

    // ====================
    // Checking and bus tasks
    // ====================
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input wb_data_t expected,
                               input wb_data_t actual);
        if (expected !== actual) begin
            abort_run($sformatf("FAIL %s: expected 0x%08h, got 0x%08h",
                                name, expected, actual));
        end
    endtask

    // One classic cycle with the request held until ack
    task automatic bus_cycle(input logic we, input wb_addr_t adr,
                             input wb_data_t dat_w, output wb_data_t dat_r);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat_w;
        @(posedge clk);
        while (!wb_ack) begin
            waited++;
            if (waited > ACK_LIMIT) begin
                abort_run($sformatf("No ack from the slave for address %0d", adr));
            end
            @(posedge clk);
        end
        // Values seen at this edge are those of the ack cycle
        dat_r  = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t unused_rd;
        bus_cycle(1'b1, adr, dat, unused_rd);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    // ====================
    // Run helpers
    // ====================
    task automatic load_operands(input int a_m [NN], input int b_m [NN]);
        for (int e = 0; e < NN; e++) begin
            wb_write(wb_addr_t'(`SA_REG_A0 + e), wb_data_t'(a_m[e]));
            wb_write(wb_addr_t'(`SA_REG_B0 + e), wb_data_t'(b_m[e]));
        end
    endtask

    // Poll STATUS until done
    task automatic wait_done();
        wb_data_t st;
        int       polls;
        polls = 0;
        wb_read(wb_addr_t'(`SA_REG_STATUS), st);
        while (!st[1]) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                abort_run("Run never reported done in the STATUS register");
            end
            wb_read(wb_addr_t'(`SA_REG_STATUS), st);
        end
        // Done set and busy clear
        check_value("STATUS", 32'h2, st);
    endtask

    task automatic check_results(input int a_m [NN], input int b_m [NN]);
        wb_data_t c_val;
        for (int i = 0; i < `SA_N; i++) begin
            for (int j = 0; j < `SA_N; j++) begin
                wb_read(wb_addr_t'(`SA_REG_C0 + i*`SA_N + j), c_val);
                check_value($sformatf("C[%0d][%0d]", i, j),
                            wb_data_t'(expect_c(a_m, b_m, i, j)), c_val);
            end
        end
    endtask

    task automatic start_and_check(input int a_m [NN], input int b_m [NN]);
        wb_write(wb_addr_t'(`SA_REG_CTRL), 32'h1);
        wait_done();
        check_results(a_m, b_m);
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        wb_data_t rd;
        int       cur_a [NN];
        int       cur_b [NN];
        clk      = 1'b0;
        rst_n    <= 1'b0;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        wb_dat_w <= '0;
        void'($urandom(5533));
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Everything reads zero after reset
        wb_read(wb_addr_t'(`SA_REG_STATUS), rd);
        check_value("STATUS", 32'h0, rd);
        for (int e = 0; e < NN; e++) begin
            wb_read(wb_addr_t'(`SA_REG_C0 + e), rd);
            check_value($sformatf("C%0d", e), 32'h0, rd);
            wb_read(wb_addr_t'(`SA_REG_A0 + e), rd);
            check_value($sformatf("A%0d", e), 32'h0, rd);
            wb_read(wb_addr_t'(`SA_REG_B0 + e), rd);
            check_value($sformatf("B%0d", e), 32'h0, rd);
        end

        // Writes truncate and reads sign-extend
        for (int e = 0; e < NN; e++) begin
            wb_write(wb_addr_t'(`SA_REG_A0 + e), RB_A[e]);
            wb_write(wb_addr_t'(`SA_REG_B0 + e), RB_B[e]);
        end
        for (int e = 0; e < NN; e++) begin
            wb_read(wb_addr_t'(`SA_REG_A0 + e), rd);
            check_value($sformatf("A%0d", e), sext_data(RB_A[e]), rd);
            wb_read(wb_addr_t'(`SA_REG_B0 + e), rd);
            check_value($sformatf("B%0d", e), sext_weight(RB_B[e]), rd);
        end

        // Table runs back to back with no carry-over
        for (int t = 0; t < N_TAB; t++) begin
            for (int e = 0; e < NN; e++) begin
                cur_a[e] = TAB_A[t][e];
                cur_b[e] = TAB_B[t][e];
            end
            load_operands(cur_a, cur_b);
            start_and_check(cur_a, cur_b);
        end

        // A missing clear would double the sum on a rerun
        start_and_check(cur_a, cur_b);

        // A write while busy is acked and dropped
        for (int e = 0; e < NN; e++) begin
            cur_a[e] = TAB_A[1][e];
            cur_b[e] = TAB_B[1][e];
        end
        load_operands(cur_a, cur_b);
        wb_write(wb_addr_t'(`SA_REG_CTRL), 32'h1);
        wb_write(wb_addr_t'(`SA_REG_A0), 32'h0000_1234);
        wait_done();
        check_results(cur_a, cur_b);
        wb_read(wb_addr_t'(`SA_REG_A0), rd);
        check_value("A0", sext_data(wb_data_t'(cur_a[0])), rd);

        // Random full 32-bit words for the operands
        for (int r = 0; r < N_RAND; r++) begin
            for (int e = 0; e < NN; e++) begin
                cur_a[e] = int'($urandom);
                cur_b[e] = int'($urandom);
            end
            load_operands(cur_a, cur_b);
            start_and_check(cur_a, cur_b);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

    // Watchdog sized from the number of runs
    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        abort_run("Timeout: the tests did not finish in the time allowed");
    end

endmodule

// ==== systolic_top.sv ====
// ====================
// 2x2 systolic multiplier behind a Wishbone classic slave
// Host loads A and B, starts a run, polls STATUS, reads C
// ====================
`timescale 1ns/10ps
`include "systolic_macros.svh"

module systolic_top import systolic_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,
    output logic     wb_ack
);

    // Sequencer controls
    logic              enable;
    logic              clear_accum;
    logic              feed_valid;

    // Unskewed operand vectors for step k
    data_t             row_data [`SA_N];
    weight_t           col_weight [`SA_N];

    // Skewed array edges
    data_t             west_data [`SA_N];
    logic [`SA_N-1:0]  west_valid;
    weight_t           north_weight [`SA_N];
    logic [`SA_N-1:0]  north_valid;

    // Results back to the register file
    accum_t            accum [`SA_N*`SA_N];
    logic              corner_valid;

    wb_systolic_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .enable       (enable),
        .clear_accum  (clear_accum),
        .feed_valid   (feed_valid),
        .row_data     (row_data),
        .col_weight   (col_weight),
        .accum        (accum),
        .corner_valid (corner_valid)
    );

    skew_feeder u_feeder (
        .clk          (clk),
        .rst_n        (rst_n),
        .feed_valid   (feed_valid),
        .row_data     (row_data),
        .col_weight   (col_weight),
        .west_data    (west_data),
        .west_valid   (west_valid),
        .north_weight (north_weight),
        .north_valid  (north_valid)
    );

    systolic_array u_array (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable       (enable),
        .clear_accum  (clear_accum),
        .west_data    (west_data),
        .west_valid   (west_valid),
        .north_weight (north_weight),
        .north_valid  (north_valid),
        .accum        (accum),
        .corner_valid (corner_valid)
    );

endmodule

// ==== wb_systolic_ctrl.sv ====
// ====================
// Wishbone classic register file and run sequencer
// Every access is acked on the next clock, no wait states
// A, B and CTRL writes are dropped while a run is busy
// ====================
`timescale 1ns/10ps
`include "systolic_macros.svh"

module wb_systolic_ctrl import systolic_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  wb_addr_t  wb_adr,
    input  wb_data_t  wb_dat_w,
    output wb_data_t  wb_dat_r,
    output logic      wb_ack,
    output logic      enable,
    output logic      clear_accum,
    output logic      feed_valid,
    output data_t     row_data [`SA_N],
    output weight_t   col_weight [`SA_N],
    input  accum_t    accum [`SA_N*`SA_N],
    input  logic      corner_valid
);

    // Index widths, one matrix index and a flat element index
    localparam int IDX_W = $clog2(`SA_N);
    localparam int NN_W  = 2 * IDX_W;

    localparam wb_addr_t A_BASE   = wb_addr_t'(`SA_REG_A0);
    localparam wb_addr_t B_BASE   = wb_addr_t'(`SA_REG_B0);
    localparam wb_addr_t C_BASE   = wb_addr_t'(`SA_REG_C0);
    localparam wb_addr_t CTRL_ADR = wb_addr_t'(`SA_REG_CTRL);
    localparam wb_addr_t STAT_ADR = wb_addr_t'(`SA_REG_STATUS);
    localparam wb_addr_t MAT_SZ   = wb_addr_t'(`SA_N * `SA_N);

    // Last k step, also last corner pulse
    localparam logic [IDX_W-1:0] K_LAST = IDX_W'(`SA_N - 1);

    seq_state_t       state;
    logic [IDX_W-1:0] k_idx;
    logic [IDX_W-1:0] drain_cnt;
    logic             busy;
    logic             done;
    logic             wb_access;
    logic             wr_en;
    logic             start;

    // Operand matrices, flat row major
    data_t            a_reg [`SA_N*`SA_N];
    weight_t          b_reg [`SA_N*`SA_N];

    wb_addr_t         a_off;
    wb_addr_t         b_off;
    wb_addr_t         c_off;
    logic             a_hit;
    logic             b_hit;
    logic             c_hit;

    // ====================
    // Bus decode
    // ====================
    // Wrap-around below a base fails the range test too
    assign a_off = wb_adr - A_BASE;
    assign b_off = wb_adr - B_BASE;
    assign c_off = wb_adr - C_BASE;
    assign a_hit = a_off < MAT_SZ;
    assign b_hit = b_off < MAT_SZ;
    assign c_hit = c_off < MAT_SZ;

    // New request only while no ack is out
    assign wb_access = wb_cyc && wb_stb && !wb_ack;
    assign wr_en     = wb_access && wb_we;
    assign start     = wr_en && !busy && (wb_adr == CTRL_ADR) && wb_dat_w[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_access;
        end
    end

    // Operand writes land on the ack edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int e = 0; e < `SA_N * `SA_N; e++) begin
                a_reg[e] <= '0;
                b_reg[e] <= '0;
            end
        end else if (wr_en && !busy) begin
            // Upper bus bits dropped
            if (a_hit) begin
                a_reg[a_off[NN_W-1:0]] <= data_t'(wb_dat_w);
            end
            if (b_hit) begin
                b_reg[b_off[NN_W-1:0]] <= weight_t'(wb_dat_w);
            end
        end
    end

    // Live read mux, sign-extended operands, unmapped reads 0
    always_comb begin
        wb_dat_r = '0;
        if (a_hit) begin
            wb_dat_r = wb_data_t'(a_reg[a_off[NN_W-1:0]]);
        end else if (b_hit) begin
            wb_dat_r = wb_data_t'(b_reg[b_off[NN_W-1:0]]);
        end else if (wb_adr == STAT_ADR) begin
            wb_dat_r = {{(`WB_DATA_W-2){1'b0}}, done, busy};
        end else if (c_hit) begin
            wb_dat_r = accum[c_off[NN_W-1:0]];
        end
    end

    // ====================
    // Run sequencer
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            k_idx     <= '0;
            drain_cnt <= '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        state <= CLEAR;
                    end
                end
                CLEAR: begin
                    state <= FEED;
                    k_idx <= '0;
                end
                FEED: begin
                    // One k step per cycle
                    if (k_idx == K_LAST) begin
                        state     <= DRAIN;
                        drain_cnt <= '0;
                    end else begin
                        k_idx <= k_idx + 1'b1;
                    end
                end
                DRAIN: begin
                    // Corner cell pulses once per k
                    if (corner_valid) begin
                        if (drain_cnt == K_LAST) begin
                            state <= DONE;
                        end else begin
                            drain_cnt <= drain_cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign busy        = (state == CLEAR) || (state == FEED) || (state == DRAIN);
    assign done        = (state == DONE);
    assign clear_accum = (state == CLEAR);
    assign feed_valid  = (state == FEED);
    // Array runs through feed and drain
    assign enable      = (state == FEED) || (state == DRAIN);

    // Column k of A and row k of B
    for (genvar g = 0; g < `SA_N; g++) begin : g_vec
        assign row_data[g]   = a_reg[{IDX_W'(g), k_idx}];
        assign col_weight[g] = b_reg[{k_idx, IDX_W'(g)}];
    end

endmodule

// ==== skew_feeder.sv ====
// ====================
// Skews the operand vectors onto the array edges
// Row g and column g are delayed g cycles, lane 0 is combinational
// ====================
`timescale 1ns/10ps
`include "systolic_macros.svh"

module skew_feeder import systolic_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              feed_valid,
    input  data_t             row_data [`SA_N],
    input  weight_t           col_weight [`SA_N],
    output data_t             west_data [`SA_N],
    output logic [`SA_N-1:0]  west_valid,
    output weight_t           north_weight [`SA_N],
    output logic [`SA_N-1:0]  north_valid
);

    for (genvar g = 0; g < `SA_N; g++) begin : g_lane
        if (g == 0) begin : g_pass
            // No skew on the first row and column
            assign west_data[g]    = row_data[g];
            assign west_valid[g]   = feed_valid;
            assign north_weight[g] = col_weight[g];
            assign north_valid[g]  = feed_valid;
        end else begin : g_delay
            data_t   d_q [g];
            weight_t w_q [g];
            logic    v_q [g];

            // Operand stages, qualified by v_q
            always_ff @(posedge clk) begin
                d_q[0] <= row_data[g];
                w_q[0] <= col_weight[g];
                for (int s = 1; s < g; s++) begin
                    d_q[s] <= d_q[s-1];
                    w_q[s] <= w_q[s-1];
                end
            end

            // Shared valid line, rows and columns stay in step
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int s = 0; s < g; s++) begin
                        v_q[s] <= 1'b0;
                    end
                end else begin
                    v_q[0] <= feed_valid;
                    for (int s = 1; s < g; s++) begin
                        v_q[s] <= v_q[s-1];
                    end
                end
            end

            assign west_data[g]    = d_q[g-1];
            assign west_valid[g]   = v_q[g-1];
            assign north_weight[g] = w_q[g-1];
            assign north_valid[g]  = v_q[g-1];
        end
    end

endmodule

// ==== systolic_array.sv ====
// ====================
// SA_N x SA_N output-stationary grid of processing elements
// Edges must arrive already skewed, east and south outputs go nowhere
// ====================
`timescale 1ns/10ps
`include "systolic_macros.svh"

module systolic_array import systolic_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              enable,
    input  logic              clear_accum,
    input  data_t             west_data [`SA_N],
    input  logic [`SA_N-1:0]  west_valid,
    input  weight_t           north_weight [`SA_N],
    input  logic [`SA_N-1:0]  north_valid,
    output accum_t            accum [`SA_N*`SA_N],
    output logic              corner_valid
);

    // ====================
    // Links between cells
    // ====================
    // Column SA_N of the data links is the east edge
    data_t   h_data  [`SA_N][`SA_N+1];
    logic    h_valid [`SA_N][`SA_N+1];
    // Row SA_N of the weight links is the south edge
    weight_t v_weight [`SA_N+1][`SA_N];
    logic    v_valid  [`SA_N+1][`SA_N];
    // Result flags per cell, row major
    logic    res_valid [`SA_N*`SA_N];

    for (genvar e = 0; e < `SA_N; e++) begin : g_edge
        // West edge feeds column 0
        assign h_data[e][0]   = west_data[e];
        assign h_valid[e][0]  = west_valid[e];
        // North edge feeds row 0
        assign v_weight[0][e] = north_weight[e];
        assign v_valid[0][e]  = north_valid[e];
    end

    // ====================
    // Cell grid
    // ====================
    for (genvar i = 0; i < `SA_N; i++) begin : g_row
        for (genvar j = 0; j < `SA_N; j++) begin : g_col
            processing_element u_pe (
                .clk              (clk),
                .rst_n            (rst_n),
                .enable           (enable),
                .clear_accum      (clear_accum),
                .data_in          (h_data[i][j]),
                .data_valid_in    (h_valid[i][j]),
                .data_out         (h_data[i][j+1]),
                .data_valid_out   (h_valid[i][j+1]),
                .weight_in        (v_weight[i][j]),
                .weight_valid_in  (v_valid[i][j]),
                .weight_out       (v_weight[i+1][j]),
                .weight_valid_out (v_valid[i+1][j]),
                .accum_out        (accum[i*`SA_N+j]),
                .result_valid     (res_valid[i*`SA_N+j])
            );
        end
    end

    // Bottom-right cell finishes last
    assign corner_valid = res_valid[`SA_N*`SA_N-1];

endmodule

// ==== processing_element.sv ====
// ====================
// One systolic cell, data moves east and weights move south
// Pass-through is one cycle, valids drop while enable is low
// ====================
`timescale 1ns/10ps

module processing_element import systolic_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    enable,
    input  logic    clear_accum,
    input  data_t   data_in,
    input  logic    data_valid_in,
    output data_t   data_out,
    output logic    data_valid_out,
    input  weight_t weight_in,
    input  logic    weight_valid_in,
    output weight_t weight_out,
    output logic    weight_valid_out,
    output accum_t  accum_out,
    output logic    result_valid
);

    logic    mac_en;
    data_t   mac_data;
    weight_t mac_weight;
    data_t   data_q;
    weight_t weight_q;
    logic    data_valid_q;
    logic    weight_valid_q;

    // ====================
    // MAC input gating
    // ====================
    // Accumulate only on a matched pair
    assign mac_en     = enable && data_valid_in && weight_valid_in;
    assign mac_data   = mac_en ? data_in : '0;
    assign mac_weight = mac_en ? weight_in : '0;

    // ====================
    // Systolic pass-through
    // ====================
    // Operands themselves qualified by the valid flags
    always_ff @(posedge clk) begin
        if (enable) begin
            data_q   <= data_in;
            weight_q <= weight_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_valid_q   <= 1'b0;
            weight_valid_q <= 1'b0;
        end else begin
            // Stalled array forwards nothing
            data_valid_q   <= enable && data_valid_in;
            weight_valid_q <= enable && weight_valid_in;
        end
    end

    assign data_out         = data_q;
    assign data_valid_out   = data_valid_q;
    assign weight_out       = weight_q;
    assign weight_valid_out = weight_valid_q;

    mac_unit u_mac (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (mac_en),
        .clear_accum (clear_accum),
        .data_in     (mac_data),
        .weight_in   (mac_weight),
        .accum_out   (accum_out),
        .valid_out   (result_valid)
    );

endmodule

// ==== mac_unit.sv ====
// ====================
// Signed multiply-accumulate, one cycle per update
// Clear wins over enable, no saturation on the 32-bit sum
// ====================
`timescale 1ns/10ps

module mac_unit import systolic_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    enable,
    input  logic    clear_accum,
    input  data_t   data_in,
    input  weight_t weight_in,
    output accum_t  accum_out,
    output logic    valid_out
);

    accum_t product;
    accum_t accum_q;
    logic   valid_q;

    // Both operands widened before the multiply
    // Full product fits in 24 bits so the 32-bit result is exact
    assign product = accum_t'(data_in) * accum_t'(weight_in);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accum_q <= '0;
            valid_q <= 1'b0;
        end else if (clear_accum) begin
            // New run starts from zero
            accum_q <= '0;
            valid_q <= 1'b0;
        end else if (enable) begin
            accum_q <= accum_q + product;
            valid_q <= 1'b1;
        end else begin
            valid_q <= 1'b0;
        end
    end

    // Valid pulses once per accumulate
    assign accum_out = accum_q;
    assign valid_out = valid_q;

endmodule

// ==== systolic_pkg.sv ====
// ====================
// Shared types for the systolic multiplier
// Widths follow systolic_macros.svh
// ====================
`include "systolic_macros.svh"

package systolic_pkg;

    // A element, S5.10
    typedef logic signed [`SA_DATA_W-1:0]   data_t;
    // B element, S1.6
    typedef logic signed [`SA_WEIGHT_W-1:0] weight_t;
    // Raw sum of products, no rescaling
    typedef logic signed [`SA_ACCUM_W-1:0]  accum_t;

    // Wishbone word address and data
    typedef logic [`WB_ADDR_W-1:0]          wb_addr_t;
    typedef logic [`WB_DATA_W-1:0]          wb_data_t;

    // Run sequencer
    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        FEED,
        DRAIN,
        DONE
    } seq_state_t;

endpackage

// ==== systolic_macros.svh ====
// ====================
// Array size, widths and register word offsets for the 2x2 multiplier
// SA_N must stay a power of two, the register decode splits offsets by bits
// ====================
`ifndef SYSTOLIC_MACROS_SVH
`define SYSTOLIC_MACROS_SVH

// Array dimension
`define SA_N            2

// Operand and result widths
`define SA_DATA_W       16
`define SA_WEIGHT_W     8
`define SA_ACCUM_W      32

// Wishbone word address and data
`define WB_ADDR_W       6
`define WB_DATA_W       32

// Register map, word offsets
`define SA_REG_A0       0
`define SA_REG_B0       4
`define SA_REG_CTRL     8
`define SA_REG_STATUS   9
`define SA_REG_C0       12

`endif
